/* all.f */
common/cpu_pkg.sv
rtl/inst_decoder.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/cpu_core.sv
test/cpu_core_tb.sv

/* Makefile */
# Verilator build and run for the pipelined CPU datapath

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Something failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulation exited with status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

   // Slots in the random part of the stream
   localparam int n_random = 400;
   // Slots in the directed opening sequence
   localparam int n_directed = 26;
   localparam int stream_len = n_random + n_directed;
   localparam int timeout_limit = 3 * stream_len + 50;

   logic clk;
   logic reset_n;
   cpu_pkg::inst_t i_inst;
   logic i_inst_valid;
   cpu_pkg::word_t o_output_port;
   logic o_output_valid;

   // Reference registers in program order
   cpu_pkg::word_t ref_regs [cpu_pkg::num_regs];
   // Expected WWD values in issue order
   cpu_pkg::word_t exp_queue [$];
   // Accepted WWD delayed by one and two edges
   logic wwd_d1;
   logic wwd_d2;
   logic seen_output = 1'b0;
   int wwd_count = 0;
   int output_count = 0;
   int cycle_count = 0;
   int value_errors = 0;
   int timing_errors = 0;
   int other_errors = 0;

   cpu_core i_dut (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Instruction encoding and reference model
   //////////////////////////////////////////////////

   function automatic cpu_pkg::inst_t make_rtype(input logic [5:0] fn,
                                                 input cpu_pkg::reg_addr_t rs,
                                                 input cpu_pkg::reg_addr_t rt,
                                                 input cpu_pkg::reg_addr_t rd);
      return {4'hF, rs, rt, rd, fn};
   endfunction

   function automatic cpu_pkg::inst_t make_itype(input logic [3:0] op,
                                                 input cpu_pkg::reg_addr_t rs,
                                                 input cpu_pkg::reg_addr_t rt,
                                                 input cpu_pkg::imm_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic is_wwd(input cpu_pkg::inst_t inst);
      return (inst[15:12] == 4'hF) && (inst[5:0] == 6'd28);
   endfunction

   // Sequential semantics of one accepted instruction
   task automatic model_inst(input cpu_pkg::inst_t inst);
      cpu_pkg::reg_addr_t rs;
      cpu_pkg::reg_addr_t rt;
      cpu_pkg::reg_addr_t rd;
      cpu_pkg::word_t a;
      cpu_pkg::word_t b;
      cpu_pkg::word_t sext;
      rs = inst[11:10];
      rt = inst[9:8];
      rd = inst[7:6];
      a = ref_regs[rs];
      b = ref_regs[rt];
      sext = {{8{inst[7]}}, inst[7:0]};
      case (inst[15:12])
         4'hF: begin
            case (inst[5:0])
               6'd0: ref_regs[rd] = a + b;
               6'd1: ref_regs[rd] = a - b;
               6'd2: ref_regs[rd] = a & b;
               6'd3: ref_regs[rd] = a | b;
               6'd4: ref_regs[rd] = ~a;
               6'd28: begin
                  exp_queue.push_back(a);
                  wwd_count++;
               end
               default: ;
            endcase
         end
         4'd4: ref_regs[rt] = a + sext;
         4'd6: ref_regs[rt] = {inst[7:0], 8'h00};
         // Unknown opcode is a bubble
         default: ;
      endcase
   endtask

   //////////////////////////////////////////////////
   // Stimulus slots
   //////////////////////////////////////////////////

   task automatic issue(input cpu_pkg::inst_t inst);
      @(posedge clk);
      i_inst <= inst;
      i_inst_valid <= 1'b1;
      model_inst(inst);
   endtask

   // Valid low with junk or a WWD on the bus
   task automatic idle_slot();
      logic [31:0] rnd;
      rnd = $urandom;
      @(posedge clk);
      if (rnd[31]) begin
         i_inst <= make_rtype(6'd28, rnd[1:0], rnd[3:2], rnd[5:4]);
      end else begin
         i_inst <= rnd[15:0];
      end
      i_inst_valid <= 1'b0;
   endtask

   // Any register writer and its destination
   task automatic random_writer(input logic [31:0] rnd, output cpu_pkg::inst_t inst,
                                output cpu_pkg::reg_addr_t dest);
      logic [2:0] sel;
      sel = rnd[18:16];
      if (sel <= 3'd4) begin
         inst = make_rtype({3'b000, sel}, rnd[1:0], rnd[3:2], rnd[5:4]);
         dest = rnd[5:4];
      end else if (sel == 3'd6) begin
         inst = make_itype(4'd6, rnd[1:0], rnd[3:2], rnd[15:8]);
         dest = rnd[3:2];
      end else begin
         inst = make_itype(4'd4, rnd[1:0], rnd[3:2], rnd[15:8]);
         dest = rnd[3:2];
      end
   endtask

   // Unknown opcode or unknown R-type func
   function automatic cpu_pkg::inst_t random_invalid(input logic [31:0] rnd);
      logic [3:0] op;
      logic [5:0] fn;
      op = rnd[19:16];
      fn = rnd[25:20];
      if (op == 4'd4 || op == 4'd6 || op == 4'hF) begin
         op = 4'd9;
      end
      if (fn <= 6'd4 || fn == 6'd28) begin
         fn = 6'd63;
      end
      if (rnd[26]) begin
         return {op, rnd[11:0]};
      end
      return make_rtype(fn, rnd[1:0], rnd[3:2], rnd[5:4]);
   endfunction

   task automatic random_item(output int used);
      int unsigned kind;
      logic [31:0] rnd;
      logic [31:0] rnd2;
      cpu_pkg::inst_t inst;
      cpu_pkg::reg_addr_t dest;
      cpu_pkg::reg_addr_t dest2;
      kind = $urandom_range(99);
      rnd = $urandom;
      used = 1;
      if (kind < 10) begin
         idle_slot();
      end else if (kind < 28) begin
         issue(make_rtype(6'd28, rnd[1:0], rnd[3:2], rnd[5:4]));
      end else if (kind < 34) begin
         issue(random_invalid(rnd));
      end else if (kind < 46) begin
         // Writer followed by a reader of its result
         random_writer(rnd, inst, dest);
         issue(inst);
         rnd2 = $urandom;
         if (rnd2[0]) begin
            issue(make_rtype(6'd28, dest, rnd2[3:2], rnd2[5:4]));
         end else begin
            random_writer(rnd2, inst, dest2);
            inst[11:10] = dest;
            issue(inst);
         end
         used = 2;
      end else begin
         random_writer(rnd, inst, dest);
         issue(inst);
      end
   endtask

   //////////////////////////////////////////////////
   // Checkers
   //////////////////////////////////////////////////

   // Expected pulse two edges after acceptance
   always @(posedge clk) begin
      if (!reset_n) begin
         wwd_d1 <= 1'b0;
         wwd_d2 <= 1'b0;
      end else begin
         wwd_d1 <= i_inst_valid && is_wwd(i_inst);
         wwd_d2 <= wwd_d1;
      end
   end

   // Compare outputs at the falling edge
   always @(negedge clk) begin
      cpu_pkg::word_t exp_data;
      if (reset_n) begin
         assert (o_output_valid === wwd_d2) else begin
            timing_errors++;
            $display("Fail at %0t: o_output_valid expected %0b, actual %0b",
                     $time, wwd_d2, o_output_valid);
         end
         if (o_output_valid) begin
            output_count++;
            seen_output = 1'b1;
            assert (exp_queue.size() > 0) else begin
               other_errors++;
               $display("Output pulse at %0t with no WWD outstanding", $time);
            end
            if (exp_queue.size() > 0) begin
               exp_data = exp_queue.pop_front();
               assert (o_output_port === exp_data) else begin
                  value_errors++;
                  $display("Fail at %0t: o_output_port expected %h, actual %h",
                           $time, exp_data, o_output_port);
               end
            end
         end else if (!seen_output) begin
            // Port is driven to zero until the first WWD
            assert (o_output_port === 16'h0000) else begin
               value_errors++;
               $display("Fail at %0t: o_output_port expected %h, actual %h",
                        $time, 16'h0000, o_output_port);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("Timeout after %0d cycles with %0d WWD results outstanding",
                  cycle_count, exp_queue.size());
         $display("Something failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int slots;
      int used;
      void'($urandom(32'hec474057));
      reset_n = 1'b0;
      i_inst = '0;
      i_inst_valid = 1'b0;
      for (int r = 0; r < cpu_pkg::num_regs; r++) begin
         ref_regs[r] = '0;
      end
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;

      // Every register reads zero after reset
      for (int r = 0; r < cpu_pkg::num_regs; r++) begin
         issue(make_rtype(6'd28, r[1:0], 2'd0, 2'd0));
      end

      // LHI then WWD at distance 1
      issue(make_itype(4'd6, 2'd0, 2'd1, 8'hA5));
      issue(make_rtype(6'd28, 2'd1, 2'd0, 2'd0));
      // Negative ADI read back through write-through
      issue(make_itype(4'd4, 2'd0, 2'd2, 8'h80));
      idle_slot();
      issue(make_rtype(6'd28, 2'd2, 2'd0, 2'd0));
      // Forwarded chain
      issue(make_itype(4'd4, 2'd2, 2'd3, 8'h7F));
      issue(make_rtype(6'd0, 2'd3, 2'd1, 2'd0));
      issue(make_rtype(6'd28, 2'd0, 2'd0, 2'd0));
      // SUB, NOT, AND, ORR back to back
      issue(make_rtype(6'd1, 2'd0, 2'd3, 2'd1));
      issue(make_rtype(6'd4, 2'd1, 2'd0, 2'd2));
      issue(make_rtype(6'd2, 2'd2, 2'd0, 2'd3));
      issue(make_rtype(6'd3, 2'd3, 2'd1, 2'd0));
      for (int r = 0; r < cpu_pkg::num_regs; r++) begin
         issue(make_rtype(6'd28, r[1:0], 2'd0, 2'd0));
      end
      // 16-bit wrap on ADD
      issue(make_itype(4'd6, 2'd0, 2'd3, 8'hFF));
      issue(make_rtype(6'd0, 2'd3, 2'd3, 2'd3));
      issue(make_rtype(6'd28, 2'd3, 2'd0, 2'd0));
      // Unknown encodings leave r3 alone
      issue(make_itype(4'd9, 2'd0, 2'd3, 8'h12));
      issue(make_rtype(6'd7, 2'd0, 2'd1, 2'd3));
      issue(make_rtype(6'd28, 2'd3, 2'd0, 2'd0));

      slots = 0;
      while (slots < n_random) begin
         random_item(used);
         slots += used;
      end
      @(posedge clk);
      i_inst_valid <= 1'b0;

      // Wait for outstanding WWD results
      while (exp_queue.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);

      assert (output_count == wwd_count) else begin
         other_errors++;
         $display("Saw %0d output pulses for %0d accepted WWDs", output_count, wwd_count);
      end

      $display("Errors: %0d value, %0d timing, %0d other over %0d WWDs",
               value_errors, timing_errors, other_errors, wwd_count);
      if (value_errors + timing_errors + other_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  logic           clk,
   input  logic           reset_n,
   input  cpu_pkg::inst_t i_inst,
   input  logic           i_inst_valid,
   output cpu_pkg::word_t o_output_port,
   output logic           o_output_valid
);

   // ID stage results
   cpu_pkg::ctrl_t id_ctrl;
   cpu_pkg::word_t id_imm_ext;
   cpu_pkg::word_t rs_data;
   cpu_pkg::word_t rt_data;
   // ID/EX register, next and current
   cpu_pkg::ex_stage_t ex_d;
   cpu_pkg::ex_stage_t ex_q;
   // EX/WB register, next and current
   cpu_pkg::wb_stage_t wb_d;
   cpu_pkg::wb_stage_t wb_q;

   //////////////////////////////////////////////////
   // ID stage
   //////////////////////////////////////////////////

   inst_decoder u_decoder (
      .i_inst       (i_inst),
      .i_inst_valid (i_inst_valid),
      .o_ctrl       (id_ctrl),
      .o_imm_ext    (id_imm_ext)
   );

   // Written from WB, write-through covers distance 2
   register_file u_regs (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_rs_addr (id_ctrl.rs),
      .i_rt_addr (id_ctrl.rt),
      .i_wb      (wb_q),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   always_comb begin
      ex_d.ctrl = id_ctrl;
      ex_d.a = rs_data;
      ex_d.b = rt_data;
      ex_d.imm_ext = id_imm_ext;
   end

   // ID/EX register
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         // Bubble in EX after reset
         ex_q.ctrl.reg_write <= 1'b0;
         ex_q.ctrl.output_write <= 1'b0;
      end else begin
         ex_q <= ex_d;
      end
   end

   //////////////////////////////////////////////////
   // EX stage
   //////////////////////////////////////////////////

   execute_stage u_execute (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_ex           (ex_q),
      .i_wb           (wb_q),
      .o_wb_next      (wb_d),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid)
   );

   //////////////////////////////////////////////////
   // WB stage
   //////////////////////////////////////////////////

   // EX/WB register, feeds RF write port and forwarding
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wb_q.reg_write <= 1'b0;
      end else begin
         wb_q <= wb_d;
      end
   end

   // Accepted WWD shows on the port two edges later
   property p_wwd_latency;
      @(posedge clk) disable iff (!reset_n)
         id_ctrl.output_write |-> ##2 o_output_valid;
   endproperty

   a_wwd_latency : assert property (p_wwd_latency)
      else $error("WWD accepted without o_output_valid two cycles later");

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  logic               clk,
   input  logic               reset_n,
   input  cpu_pkg::ex_stage_t i_ex,
   input  cpu_pkg::wb_stage_t i_wb,
   output cpu_pkg::wb_stage_t o_wb_next,
   output cpu_pkg::word_t     o_output_port,
   output logic               o_output_valid
);

   // Operands after forwarding
   cpu_pkg::word_t a_fwd;
   cpu_pkg::word_t b_fwd;
   // Second ALU input after source select
   cpu_pkg::word_t alu_b;
   cpu_pkg::word_t alu_result;
   // WB stage holds the register this stage reads
   logic fwd_a;
   logic fwd_b;

   //////////////////////////////////////////////////
   // Forwarding from WB
   //////////////////////////////////////////////////

   // Only WB can be one instruction ahead
   assign fwd_a = i_wb.reg_write && (i_wb.write_reg == i_ex.ctrl.rs);
   assign fwd_b = i_wb.reg_write && (i_wb.write_reg == i_ex.ctrl.rt);

   assign a_fwd = fwd_a ? i_wb.data : i_ex.a;
   assign b_fwd = fwd_b ? i_wb.data : i_ex.b;

   //////////////////////////////////////////////////
   // ALU
   //////////////////////////////////////////////////

   // ADI takes the sign-extended immediate
   assign alu_b = (i_ex.ctrl.src_b == cpu_pkg::SRC_B_IMM) ? i_ex.imm_ext : b_fwd;

   always_comb begin
      case (i_ex.ctrl.alu_op)
         cpu_pkg::ALU_ADD: alu_result = a_fwd + alu_b;
         cpu_pkg::ALU_SUB: alu_result = a_fwd - alu_b;
         cpu_pkg::ALU_AND: alu_result = a_fwd & alu_b;
         cpu_pkg::ALU_ORR: alu_result = a_fwd | alu_b;
         // NOT uses rs only
         cpu_pkg::ALU_NOT: alu_result = ~a_fwd;
         default: alu_result = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // Write-back bundle
   //////////////////////////////////////////////////

   always_comb begin
      o_wb_next.reg_write = i_ex.ctrl.reg_write;
      o_wb_next.write_reg = i_ex.ctrl.write_reg;
      // LHI bypasses the ALU
      if (i_ex.ctrl.wb_src == cpu_pkg::WB_IMM) begin
         o_wb_next.data = i_ex.imm_ext;
      end else begin
         o_wb_next.data = alu_result;
      end
   end

   //////////////////////////////////////////////////
   // Output port
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_output_port <= '0;
         o_output_valid <= 1'b0;
      end else begin
         // One pulse per WWD in EX
         o_output_valid <= i_ex.ctrl.output_write;
         // WWD sees forwarded rs as well
         if (i_ex.ctrl.output_write) begin
            o_output_port <= a_fwd;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic               clk,
   input  logic               reset_n,
   input  cpu_pkg::reg_addr_t i_rs_addr,
   input  cpu_pkg::reg_addr_t i_rt_addr,
   input  cpu_pkg::wb_stage_t i_wb,
   output cpu_pkg::word_t     o_rs_data,
   output cpu_pkg::word_t     o_rt_data
);

   // Register storage
   cpu_pkg::word_t regs [cpu_pkg::num_regs];
   // Read address hits the register being written this cycle
   logic rs_hit;
   logic rt_hit;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         // All registers read zero after reset
         for (int i = 0; i < cpu_pkg::num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb.reg_write) begin
         regs[i_wb.write_reg] <= i_wb.data;
      end
   end

   //////////////////////////////////////////////////
   // Read ports with write-through
   //////////////////////////////////////////////////

   assign rs_hit = i_wb.reg_write && (i_wb.write_reg == i_rs_addr);
   assign rt_hit = i_wb.reg_write && (i_wb.write_reg == i_rt_addr);

   // Same-cycle write returns the new value
   assign o_rs_data = rs_hit ? i_wb.data : regs[i_rs_addr];
   assign o_rt_data = rt_hit ? i_wb.data : regs[i_rt_addr];

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
   input  cpu_pkg::inst_t i_inst,
   input  logic           i_inst_valid,
   output cpu_pkg::ctrl_t o_ctrl,
   output cpu_pkg::word_t o_imm_ext
);

   //////////////////////////////////////////////////
   // Instruction fields
   //////////////////////////////////////////////////

   logic [cpu_pkg::opcode_w-1:0] opcode;
   logic [cpu_pkg::func_w-1:0] func;
   cpu_pkg::reg_addr_t rs;
   cpu_pkg::reg_addr_t rt;
   cpu_pkg::reg_addr_t rd;
   cpu_pkg::imm_t imm;
   // Instruction writes a register / drives the output port
   logic wr_en;
   logic out_en;

   assign opcode = i_inst[15:12];
   assign rs = i_inst[11:10];
   assign rt = i_inst[9:8];
   assign rd = i_inst[7:6];
   assign func = i_inst[5:0];
   assign imm = i_inst[7:0];

   //////////////////////////////////////////////////
   // Control word
   //////////////////////////////////////////////////

   always_comb begin
      // Defaults describe a bubble
      o_ctrl = '0;
      o_ctrl.alu_op = cpu_pkg::ALU_ADD;
      o_ctrl.src_b = cpu_pkg::SRC_B_REG;
      o_ctrl.wb_src = cpu_pkg::WB_ALU;
      o_ctrl.rs = rs;
      o_ctrl.rt = rt;
      // I-type destination is rt
      o_ctrl.write_reg = rt;
      wr_en = 1'b0;
      out_en = 1'b0;
      case (opcode)
         cpu_pkg::OP_RTYPE: begin
            o_ctrl.write_reg = rd;
            case (func)
               cpu_pkg::FUNC_ADD: begin
                  o_ctrl.alu_op = cpu_pkg::ALU_ADD;
                  wr_en = 1'b1;
               end
               cpu_pkg::FUNC_SUB: begin
                  o_ctrl.alu_op = cpu_pkg::ALU_SUB;
                  wr_en = 1'b1;
               end
               cpu_pkg::FUNC_AND: begin
                  o_ctrl.alu_op = cpu_pkg::ALU_AND;
                  wr_en = 1'b1;
               end
               cpu_pkg::FUNC_ORR: begin
                  o_ctrl.alu_op = cpu_pkg::ALU_ORR;
                  wr_en = 1'b1;
               end
               cpu_pkg::FUNC_NOT: begin
                  o_ctrl.alu_op = cpu_pkg::ALU_NOT;
                  wr_en = 1'b1;
               end
               // WWD sends rs to the port, no write-back
               cpu_pkg::FUNC_WWD: out_en = 1'b1;
               default: ;
            endcase
         end
         cpu_pkg::OP_ADI: begin
            o_ctrl.src_b = cpu_pkg::SRC_B_IMM;
            wr_en = 1'b1;
         end
         cpu_pkg::OP_LHI: begin
            o_ctrl.wb_src = cpu_pkg::WB_IMM;
            wr_en = 1'b1;
         end
         default: ;
      endcase
      // No strobe, no side effects
      o_ctrl.reg_write = wr_en & i_inst_valid;
      o_ctrl.output_write = out_en & i_inst_valid;
   end

   // LHI puts imm in the upper byte, everything else sign-extends
   assign o_imm_ext = (opcode == cpu_pkg::OP_LHI) ? {imm, 8'h00} : {{8{imm[7]}}, imm};

   // WWD is the only output writer and never writes back
   always_comb begin
      assert (!(o_ctrl.reg_write && o_ctrl.output_write))
         else $error("decoder raised reg_write and output_write together");
   end

endmodule

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   //////////////////////////////////////////////////
   // Widths and sizes
   //////////////////////////////////////////////////

   // Datapath and instruction width
   localparam int word_w = 16;
   // Four registers, two address bits
   localparam int reg_addr_w = 2;
   localparam int num_regs = 4;
   // Instruction field widths
   localparam int imm_w = 8;
   localparam int opcode_w = 4;
   localparam int func_w = 6;
   // ALU op encoding width
   localparam int alu_op_w = 3;

   typedef logic [word_w-1:0] word_t;
   typedef logic [word_w-1:0] inst_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [imm_w-1:0] imm_t;

   //////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////

   // Supported opcodes, bits 15..12
   typedef enum logic [opcode_w-1:0] {
      OP_ADI = 4'd4,
      OP_LHI = 4'd6,
      OP_RTYPE = 4'd15
   } opcode_e;

   // R-type function codes, bits 5..0
   typedef enum logic [func_w-1:0] {
      FUNC_ADD = 6'd0,
      FUNC_SUB = 6'd1,
      FUNC_AND = 6'd2,
      FUNC_ORR = 6'd3,
      FUNC_NOT = 6'd4,
      FUNC_WWD = 6'd28
   } func_e;

   // ALU operations
   typedef enum logic [alu_op_w-1:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_ORR = 3'd3,
      ALU_NOT = 3'd4
   } alu_op_e;

   // Second ALU operand
   typedef enum logic {
      SRC_B_REG = 1'b0,
      SRC_B_IMM = 1'b1
   } src_b_e;

   // Write-back data source
   typedef enum logic {
      WB_ALU = 1'b0,
      WB_IMM = 1'b1
   } wb_src_e;

   //////////////////////////////////////////////////
   // Stage bundles
   //////////////////////////////////////////////////

   // Decoded control word, produced in ID
   typedef struct packed {
      alu_op_e alu_op;
      src_b_e src_b;
      wb_src_e wb_src;
      logic reg_write;
      logic output_write;
      reg_addr_t write_reg;
      reg_addr_t rs;
      reg_addr_t rt;
   } ctrl_t;

   // ID/EX pipeline register contents
   typedef struct packed {
      ctrl_t ctrl;
      word_t a;
      word_t b;
      word_t imm_ext;
   } ex_stage_t;

   // EX/WB pipeline register contents, also the RF write port
   typedef struct packed {
      logic reg_write;
      reg_addr_t write_reg;
      word_t data;
   } wb_stage_t;

endpackage

`default_nettype wire
